/* verilog/guess_pkg.sv */
`default_nettype none

package guess_pkg;

	//////////////////////////////////////////////////////////////////////
	// board geometry and word widths
	//////////////////////////////////////////////////////////////////////

	localparam int DIGITS   = 4;		// seven-segment places, place 0 is rightmost
	localparam int NIBBLE_W = 4;		// one hex digit
	localparam int WORD_W   = DIGITS * NIBBLE_W;	// secret and guess words
	localparam int SEG_W    = 8;		// dp plus 7 segments, all active low
	localparam int CODE_W   = NIBBLE_W + 1;	// display code, blank flag on top

	//////////////////////////////////////////////////////////////////////
	// display code
	//////////////////////////////////////////////////////////////////////

	// one 5-bit word per place, read two ways by the segment decoder
	typedef union packed
	{
		struct packed
		{
			logic                blank;	// 0 = show nibble as hex
			logic [NIBBLE_W-1:0] nibble;	// hex value when not blank
		} digit;
		logic [CODE_W-1:0] glyph;		// letter number when blank flag set
	} disp_code_t;

	// letters live in the upper half, where the blank flag is set
	localparam logic [CODE_W-1:0] GLYPH_P     = 5'b10001;	// banner P
	localparam logic [CODE_W-1:0] GLYPH_L     = 5'b10010;	// banner L, hint LO
	localparam logic [CODE_W-1:0] GLYPH_H     = 5'b10011;	// hint HI
	localparam logic [CODE_W-1:0] GLYPH_BLANK = 5'b11111;	// all segments off

	//////////////////////////////////////////////////////////////////////
	// game states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0]
	{
		ST_BANNER1 = 3'd0,	// "PL 1" after reset
		ST_ENTRY1  = 3'd1,	// player 1 builds the secret
		ST_BANNER2 = 3'd2,	// "PL 2" once the turn switch is up
		ST_GUESS   = 3'd3,	// player 2 enters and submits
		ST_HINT_HI = 3'd4,	// "2 HI", guess above secret
		ST_HINT_LO = 3'd5,	// "2 LO", guess below secret
		ST_WON     = 3'd6	// guess count shown, leds flash
	} game_state_t;

endpackage

`default_nettype wire

/* verilog/digit_entry.sv */
`timescale 1ns/1ns
`default_nettype none

module digit_entry (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [guess_pkg::NIBBLE_W-1:0] switch,	// value switches
	input  logic [guess_pkg::DIGITS-1:0]   btn,		// one button per place
	input  logic                          turn_sw,	// up hands over to player 2
	input  logic                          guess_sw,	// up then down submits
	output logic [guess_pkg::WORD_W-1:0]   secret,
	output logic [guess_pkg::WORD_W-1:0]   guess,
	output logic [guess_pkg::DIGITS-1:0]   secret_shown,
	output logic [guess_pkg::DIGITS-1:0]   guess_shown,
	output logic                          p2_active,
	output logic                          submit
);
	import guess_pkg::*;

	logic [DIGITS-1:0] btn_q;	// button levels last cycle
	logic              turn_q;	// turn switch last cycle
	logic              guess_q;	// guess switch last cycle
	logic              press;	// clean single-button press
	logic              turn_rise;
	logic              guess_fall;

	//////////////////////////////////////////////////////////////////////
	// input history and edge detect
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			btn_q   <= '0;
			turn_q  <= 1'b0;
			guess_q <= 1'b0;
		end
		else
		begin
			btn_q   <= btn;
			turn_q  <= turn_sw;
			guess_q <= guess_sw;
		end
	end

	// from all released to exactly one held, chords are ignored
	assign press      = (btn_q == '0) && (btn != '0) && ((btn & (btn - 1'b1)) == '0);
	assign turn_rise  = turn_sw & ~turn_q;
	assign guess_fall = guess_q & ~guess_sw;

	//////////////////////////////////////////////////////////////////////
	// digit register files
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			secret       <= '0;
			guess        <= '0;
			secret_shown <= '0;	// every place starts blank
			guess_shown  <= '0;
		end
		else if (press)
		begin
			for (int i = 0; i < DIGITS; i++)
			begin
				if (btn[i] && p2_active)	// guess side once turn handed over
				begin
					guess[i*NIBBLE_W +: NIBBLE_W] <= switch;
					guess_shown[i]                <= 1'b1;
				end
				else if (btn[i])		// secret frozen after turn
				begin
					secret[i*NIBBLE_W +: NIBBLE_W] <= switch;
					secret_shown[i]                <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			p2_active <= 1'b0;
			submit    <= 1'b0;
		end
		else
		begin
			p2_active <= p2_active | turn_rise;	// sticky until reset
			submit    <= guess_fall & p2_active;	// single-cycle pulse
		end
	end

	a_submit_p2 : assert property (@(posedge clk) disable iff (!rst_n) submit |-> p2_active);

endmodule

`default_nettype wire

/* verilog/game_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module game_fsm #(
	parameter int BANNER_CYCLES = 40,	// banner dwell in clk cycles
	parameter int HINT_CYCLES   = 32,	// hint dwell in clk cycles
	parameter int FLASH_CYCLES  = 8		// led half period
) (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic [guess_pkg::WORD_W-1:0]              secret,
	input  logic [guess_pkg::WORD_W-1:0]              guess,
	input  logic                                     p2_active,
	input  logic                                     submit,
	output guess_pkg::game_state_t                   state,
	output logic [guess_pkg::DIGITS*guess_pkg::NIBBLE_W-1:0] count_bcd,
	output logic [7:0]                               led
);
	import guess_pkg::*;

	localparam int DWELL_MAX = (BANNER_CYCLES > HINT_CYCLES) ? BANNER_CYCLES : HINT_CYCLES;
	localparam int DWELL_W   = $clog2(DWELL_MAX + 1);
	localparam int FLASH_W   = $clog2(FLASH_CYCLES + 1);

	localparam logic [DWELL_W-1:0] BANNER_LAST = DWELL_W'(BANNER_CYCLES - 1);
	localparam logic [DWELL_W-1:0] HINT_LAST   = DWELL_W'(HINT_CYCLES - 1);
	localparam logic [FLASH_W-1:0] FLASH_LAST  = FLASH_W'(FLASH_CYCLES - 1);

	logic [DWELL_W-1:0]           dwell;	// shared banner and hint timer
	logic [FLASH_W-1:0]           flash;	// led half period timer
	logic                         accept;	// submit that counts
	logic                         carry;	// bcd ripple carry
	logic [DIGITS*NIBBLE_W-1:0]   count_next;

	assign accept = submit && (state == ST_GUESS);	// elsewhere submits are dropped

	//////////////////////////////////////////////////////////////////////
	// state sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= ST_BANNER1;
			dwell <= '0;
		end
		else
		begin
			dwell <= '0;	// every state change restarts the timer
			case (state)
			ST_BANNER1:
			begin
				if (dwell == BANNER_LAST)
					state <= ST_ENTRY1;
				else
					dwell <= dwell + 1'b1;
			end
			ST_ENTRY1:
			begin
				if (p2_active)
					state <= ST_BANNER2;	// turn switch went up
			end
			ST_BANNER2:
			begin
				if (dwell == BANNER_LAST)
					state <= ST_GUESS;
				else
					dwell <= dwell + 1'b1;
			end
			ST_GUESS:
			begin
				if (accept && (guess > secret))
					state <= ST_HINT_HI;
				else if (accept && (guess < secret))
					state <= ST_HINT_LO;
				else if (accept)
					state <= ST_WON;	// exact match
			end
			ST_HINT_HI, ST_HINT_LO:
			begin
				if (dwell == HINT_LAST)
					state <= ST_GUESS;
				else
					dwell <= dwell + 1'b1;
			end
			ST_WON:
				state <= ST_WON;	// held until reset
			default:
				state <= ST_BANNER1;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// guess counter and led flasher
	//////////////////////////////////////////////////////////////////////

	// four bcd digits, ripple from the ones place, 9999 wraps to 0000
	always_comb
	begin
		count_next = count_bcd;
		carry      = accept;
		for (int i = 0; i < DIGITS; i++)
		begin
			if (carry && (count_bcd[i*NIBBLE_W +: NIBBLE_W] == NIBBLE_W'(9)))
				count_next[i*NIBBLE_W +: NIBBLE_W] = '0;	// carry ripples on
			else if (carry)
			begin
				count_next[i*NIBBLE_W +: NIBBLE_W] = count_bcd[i*NIBBLE_W +: NIBBLE_W] + 1'b1;
				carry = 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			count_bcd <= '0;
			flash     <= '0;
			led       <= '0;
		end
		else
		begin
			count_bcd <= count_next;
			if (state != ST_WON)
			begin
				flash <= '0;
				led   <= '0;	// dark until the game is won
			end
			else if (flash == FLASH_LAST)
			begin
				flash <= '0;
				led   <= ~led;	// all eight together
			end
			else
				flash <= flash + 1'b1;
		end
	end

	a_state_legal : assert property (@(posedge clk) disable iff (!rst_n)
		state inside {ST_BANNER1, ST_ENTRY1, ST_BANNER2, ST_GUESS,
			ST_HINT_HI, ST_HINT_LO, ST_WON});

	a_count_in_guess : assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && (count_bcd != $past(count_bcd)) |-> $past(state) == ST_GUESS);

endmodule

`default_nettype wire

/* verilog/display_scan.sv */
`timescale 1ns/1ns
`default_nettype none

module display_scan #(
	parameter int SCAN_DIV = 4	// clk cycles per anode step
) (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  guess_pkg::game_state_t                   state,
	input  logic [guess_pkg::WORD_W-1:0]              secret,
	input  logic [guess_pkg::WORD_W-1:0]              guess,
	input  logic [guess_pkg::DIGITS-1:0]              secret_shown,
	input  logic [guess_pkg::DIGITS-1:0]              guess_shown,
	input  logic [guess_pkg::DIGITS*guess_pkg::NIBBLE_W-1:0] count_bcd,
	output logic [guess_pkg::DIGITS-1:0]              anodes,	// one-cold, low is lit
	output logic [guess_pkg::SEG_W-1:0]               cathodes	// active low
);
	import guess_pkg::*;

	localparam int DIV_W   = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam int PLACE_W = $clog2(DIGITS);

	logic [DIV_W-1:0]   scan_cnt;
	logic               step;		// advance to next place
	logic [PLACE_W-1:0] place;		// place currently lit
	logic [PLACE_W-1:0] place_n;
	logic               scan_on;	// low until first step after reset
	logic               scan_on_n;
	disp_code_t         code;		// what place_n should show

	function automatic disp_code_t hex_code(input logic [NIBBLE_W-1:0] value);
		disp_code_t c;
		c.digit.blank  = 1'b0;
		c.digit.nibble = value;
		return c;
	endfunction

	// entered digits only, untouched places stay dark
	function automatic disp_code_t entry_code(input logic shown, input logic [NIBBLE_W-1:0] value);
		disp_code_t c;
		c = shown ? hex_code(value) : GLYPH_BLANK;
		return c;
	endfunction

	function automatic logic [SEG_W-1:0] seg_decode(input disp_code_t c);
		logic [SEG_W-1:0] seg;
		seg = '1;
		if (!c.digit.blank)
			case (c.digit.nibble)
			4'h0: seg = 8'b11000000;
			4'h1: seg = 8'b11111001;
			4'h2: seg = 8'b10100100;
			4'h3: seg = 8'b10110000;
			4'h4: seg = 8'b10011001;
			4'h5: seg = 8'b10010010;
			4'h6: seg = 8'b10000010;
			4'h7: seg = 8'b11111000;
			4'h8: seg = 8'b10000000;
			4'h9: seg = 8'b10010000;
			4'ha: seg = 8'b10001000;
			4'hb: seg = 8'b10000011;
			4'hc: seg = 8'b11000110;
			4'hd: seg = 8'b10100001;
			4'he: seg = 8'b10000110;
			default: seg = 8'b10001110;	// f
			endcase
		else
			case (c.glyph)
			GLYPH_P: seg = 8'b10001100;
			GLYPH_L: seg = 8'b11000111;
			GLYPH_H: seg = 8'b10001001;
			default: seg = '1;		// blank and unused letters
			endcase
		return seg;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// per-place code selection
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		code = GLYPH_BLANK;
		case (state)
		ST_BANNER1, ST_BANNER2:	// "PL 1" / "PL 2"
			case (place_n)
			2'd3: code = GLYPH_P;
			2'd2: code = GLYPH_L;
			2'd1: code = GLYPH_BLANK;
			default: code = hex_code((state == ST_BANNER1) ? 4'd1 : 4'd2);
			endcase
		ST_ENTRY1:
			code = entry_code(secret_shown[place_n], secret[place_n*NIBBLE_W +: NIBBLE_W]);
		ST_GUESS:
			code = entry_code(guess_shown[place_n], guess[place_n*NIBBLE_W +: NIBBLE_W]);
		ST_HINT_HI, ST_HINT_LO:	// "2 HI" / "2 LO", digits stand in for I and O
			case (place_n)
			2'd3: code = hex_code(4'd2);
			2'd2: code = GLYPH_BLANK;
			2'd1: code = (state == ST_HINT_HI) ? GLYPH_H : GLYPH_L;
			default: code = hex_code((state == ST_HINT_HI) ? 4'd1 : 4'd0);
			endcase
		ST_WON:
			code = hex_code(count_bcd[place_n*NIBBLE_W +: NIBBLE_W]);
		default:
			code = GLYPH_BLANK;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// anode strobe, cathodes registered alongside
	//////////////////////////////////////////////////////////////////////

	assign step      = (scan_cnt == DIV_W'(SCAN_DIV - 1));
	assign scan_on_n = scan_on | step;
	assign place_n   = !step ? place :
		(!scan_on || (place == PLACE_W'(DIGITS - 1))) ? '0 : place + 1'b1;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			scan_cnt <= '0;
			place    <= '0;
			scan_on  <= 1'b0;
			anodes   <= '1;	// all places dark
			cathodes <= '1;
		end
		else
		begin
			scan_cnt <= step ? '0 : scan_cnt + 1'b1;
			place    <= place_n;
			scan_on  <= scan_on_n;
			anodes   <= scan_on_n ? ~(DIGITS'(1) << place_n) : '1;
			cathodes <= scan_on_n ? seg_decode(code) : '1;	// follows content every cycle
		end
	end

	a_one_anode : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~anodes));

endmodule

`default_nettype wire

/* verilog/guess_game_top.sv */
`timescale 1ns/1ns
`default_nettype none

module guess_game_top #(
	parameter int SCAN_DIV      = 4,	// clk cycles per anode step
	parameter int BANNER_CYCLES = 40,	// "PL 1" and "PL 2" dwell
	parameter int HINT_CYCLES   = 32,	// "2 HI" and "2 LO" dwell
	parameter int FLASH_CYCLES  = 8		// led half period when won
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [guess_pkg::NIBBLE_W-1:0] switch,	// switches 3..0
	input  logic [guess_pkg::DIGITS-1:0]   btn,		// place select buttons
	input  logic                          turn_sw,	// switch 4
	input  logic                          guess_sw,	// switch 5
	output logic [7:0]                    led,
	output logic [guess_pkg::SEG_W-1:0]    cathodes,
	output logic [guess_pkg::DIGITS-1:0]   anodes
);
	import guess_pkg::*;

	logic [WORD_W-1:0]          secret;
	logic [WORD_W-1:0]          guess;
	logic [DIGITS-1:0]          secret_shown;
	logic [DIGITS-1:0]          guess_shown;
	logic                       p2_active;
	logic                       submit;
	game_state_t                state;
	logic [DIGITS*NIBBLE_W-1:0] count_bcd;

	digit_entry u_entry (
		.clk(clk), .rst_n(rst_n),
		.switch(switch), .btn(btn), .turn_sw(turn_sw), .guess_sw(guess_sw),
		.secret(secret), .guess(guess),
		.secret_shown(secret_shown), .guess_shown(guess_shown),
		.p2_active(p2_active), .submit(submit)
	);

	game_fsm #(
		.BANNER_CYCLES(BANNER_CYCLES), .HINT_CYCLES(HINT_CYCLES), .FLASH_CYCLES(FLASH_CYCLES)
	) u_fsm (
		.clk(clk), .rst_n(rst_n),
		.secret(secret), .guess(guess), .p2_active(p2_active), .submit(submit),
		.state(state), .count_bcd(count_bcd), .led(led)
	);

	display_scan #(.SCAN_DIV(SCAN_DIV)) u_scan (
		.clk(clk), .rst_n(rst_n), .state(state),
		.secret(secret), .guess(guess),
		.secret_shown(secret_shown), .guess_shown(guess_shown),
		.count_bcd(count_bcd), .anodes(anodes), .cathodes(cathodes)
	);

endmodule

`default_nettype wire

/* bench/tb_guess_game.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_guess_game;

	localparam int SCAN_DIV      = 4;	// DUT runs with its defaults
	localparam int BANNER_CYCLES = 40;
	localparam int HINT_CYCLES   = 32;
	localparam int FLASH_CYCLES  = 8;
	localparam int MAX_ROWS      = 20;

	localparam int ACT_WAIT   = 0;	// only idle cycles
	localparam int ACT_PRESS  = 1;	// one button with a switch value
	localparam int ACT_WORD   = 2;	// all four places, place 0 first
	localparam int ACT_TURN   = 3;	// turn switch up, left up
	localparam int ACT_SUBMIT = 4;	// guess switch up then down

	logic       clk;
	logic       rst_n;
	logic [3:0] switch;
	logic [3:0] btn;
	logic       turn_sw;
	logic       guess_sw;
	logic [7:0] led;
	logic [7:0] cathodes;
	logic [3:0] anodes;

	int          row_act   [MAX_ROWS];
	int          row_place [MAX_ROWS];
	logic [15:0] row_value [MAX_ROWS];
	int          row_wait  [MAX_ROWS];	// idle cycles after the action
	logic [31:0] row_text  [MAX_ROWS];	// four chars, leftmost is place 3
	logic        row_disp  [MAX_ROWS];	// scan the display afterwards
	logic        row_flash [MAX_ROWS];	// leds flashing instead of dark
	string       row_name  [MAX_ROWS];
	int          n_rows;
	int          row_errs;
	int          n_pass;
	int          n_fail;
	int          watch_cycles;
	logic        table_done;
	logic [31:0] rng;
	logic [15:0] secret_w;
	logic [15:0] hi_w;
	logic [15:0] lo_w;
	logic [3:0]  first_v;	// value that gets overwritten

	guess_game_top DUT (
		.clk(clk), .rst_n(rst_n), .switch(switch), .btn(btn),
		.turn_sw(turn_sw), .guess_sw(guess_sw),
		.led(led), .cathodes(cathodes), .anodes(anodes)
	);

	always #5 clk = ~clk;	// 10 ns period

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		logic [7:0] c;
		if (n < 4'd10)
			c = 8'h30 + {4'h0, n};	// '0'..'9'
		else
			c = 8'h37 + {4'h0, n};	// 'A'..'F'
		return c;
	endfunction

	// entered places as hex, the rest as spaces
	function automatic logic [31:0] digits_text(input logic [15:0] word, input logic [3:0] mask);
		logic [31:0] t;
		for (int p = 0; p < 4; p++)
			t[p*8 +: 8] = mask[p] ? hex_char(word[p*4 +: 4]) : 8'h20;
		return t;
	endfunction

	// standard active-low segments, dp off in bit 7
	function automatic logic [7:0] char_segments(input logic [7:0] c);
		logic [7:0] s;
		case (c)
		"0", "O": s = 8'hc0;
		"1", "I": s = 8'hf9;
		"2": s = 8'ha4;
		"3": s = 8'hb0;
		"4": s = 8'h99;
		"5": s = 8'h92;
		"6": s = 8'h82;
		"7": s = 8'hf8;
		"8": s = 8'h80;
		"9": s = 8'h90;
		"A": s = 8'h88;
		"B": s = 8'h83;	// lower-case b
		"C": s = 8'hc6;
		"D": s = 8'ha1;	// lower-case d
		"E": s = 8'h86;
		"F": s = 8'h8e;
		"P": s = 8'h8c;
		"L": s = 8'hc7;
		"H": s = 8'h89;
		default: s = 8'hff;	// space
		endcase
		return s;
	endfunction

	task automatic add_row(input string name, input int act, input int place,
		input logic [15:0] value, input int cycles, input logic [31:0] text,
		input logic disp, input logic flash);
		row_name[n_rows]  = name;
		row_act[n_rows]   = act;
		row_place[n_rows] = place;
		row_value[n_rows] = value;
		row_wait[n_rows]  = cycles;
		row_text[n_rows]  = text;
		row_disp[n_rows]  = disp;
		row_flash[n_rows] = flash;
		n_rows++;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;	// inputs move just after the edge
	endtask

	task automatic press_place(input int place, input logic [3:0] value);
		next_cycle();
		switch = value;
		btn    = 4'b0001 << place;
		next_cycle();
		next_cycle();
		btn = 4'b0000;	// release so the next press is seen
	endtask

	task automatic enter_word(input logic [15:0] word);
		for (int p = 0; p < 4; p++)
			press_place(p, word[p*4 +: 4]);
	endtask

	task automatic raise_turn();
		next_cycle();
		turn_sw = 1'b1;
		repeat (3) next_cycle();	// p2_active, state, cathodes
	endtask

	task automatic submit_guess();
		next_cycle();
		guess_sw = 1'b1;
		next_cycle();
		next_cycle();
		guess_sw = 1'b0;	// falling edge submits
		repeat (3) next_cycle();	// pulse, state, cathodes
	endtask

	// one full scan, latest cathodes per lit place
	task automatic check_display(input logic [31:0] text);
		logic [7:0] seen [4];
		logic [3:0] visited;
		int         p;
		visited = 4'h0;
		for (int c = 0; c < 8*SCAN_DIV && visited != 4'hf; c++)
		begin
			@(negedge clk);
			for (p = 0; p < 4; p++)
				if (anodes == ~(4'b0001 << p))
				begin
					seen[p]    = cathodes;
					visited[p] = 1'b1;
				end
		end
		assert (visited == 4'hf) else
		begin
			$display("display scan did not light all four places by %0t ns", $time);
			row_errs++;
		end
		for (p = 0; p < 4; p++)
			if (visited[p])
				assert (seen[p] == char_segments(text[p*8 +: 8])) else
				begin
					$display("FAILED at %0t ns: place %0d shows %h, expected '%s' (%h)",
						$time, p, seen[p], text[p*8 +: 8], char_segments(text[p*8 +: 8]));
					row_errs++;
				end
	endtask

	// any phase, but every full level lasts FLASH_CYCLES
	task automatic check_flash();
		logic [7:0] prev;
		int         run;
		int         toggles;
		@(negedge clk);
		prev    = led;
		run     = 0;
		toggles = 0;
		for (int c = 0; c < 4*FLASH_CYCLES; c++)
		begin
			@(negedge clk);
			assert (led == 8'h00 || led == 8'hff) else
			begin
				$display("FAILED at %0t ns: leds %h not all equal", $time, led);
				row_errs++;
			end
			if (led != prev && toggles > 0)
				assert (run == FLASH_CYCLES) else
				begin
					$display("FAILED at %0t ns: led level held %0d cycles, expected %0d",
						$time, run, FLASH_CYCLES);
					row_errs++;
				end
			if (led != prev)
			begin
				toggles++;
				run = 1;
			end
			else
				run++;
			prev = led;
		end
		assert (toggles >= 2) else
		begin
			$display("leds did not keep flashing after the win at %0t ns", $time);
			row_errs++;
		end
	endtask

	task automatic report_test(input int num, input string name);
		if (row_errs == 0)
			n_pass++;
		else
			n_fail++;
		$display("test %0d %s: %s", num, name, (row_errs == 0) ? "pass" : "fail");
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic build_table();
		rng      = xorshift32(rng);
		secret_w = 16'h1000 + 16'(rng % 32'he000);	// leaves room above and below
		rng      = xorshift32(rng);
		hi_w     = secret_w + 16'd1 + 16'(rng % (32'hffff - {16'h0, secret_w}));
		rng      = xorshift32(rng);
		lo_w     = 16'(rng % {16'h0, secret_w});
		first_v  = secret_w[11:8] ^ 4'h5;
		n_rows   = 0;
		add_row("banner 1", ACT_WAIT, 0, 16'h0, 0, "PL 1", 1'b1, 1'b0);
		add_row("entry blank", ACT_WAIT, 0, 16'h0, BANNER_CYCLES, "    ", 1'b1, 1'b0);
		add_row("first press", ACT_PRESS, 2, {12'h0, first_v}, 0,
			digits_text({4'h0, first_v, 8'h0}, 4'b0100), 1'b1, 1'b0);
		add_row("overwrite", ACT_PRESS, 2, {12'h0, secret_w[11:8]}, 0,
			digits_text(secret_w, 4'b0100), 1'b1, 1'b0);
		add_row("place 0", ACT_PRESS, 0, {12'h0, secret_w[3:0]}, 0,
			digits_text(secret_w, 4'b0101), 1'b1, 1'b0);
		add_row("place 1", ACT_PRESS, 1, {12'h0, secret_w[7:4]}, 0,
			digits_text(secret_w, 4'b0111), 1'b1, 1'b0);
		add_row("place 3", ACT_PRESS, 3, {12'h0, secret_w[15:12]}, 0,
			digits_text(secret_w, 4'b1111), 1'b1, 1'b0);
		add_row("turn", ACT_TURN, 0, 16'h0, 0, "PL 2", 1'b1, 1'b0);
		add_row("guess blank", ACT_WAIT, 0, 16'h0, BANNER_CYCLES, "    ", 1'b1, 1'b0);
		add_row("high guess entry", ACT_WORD, 0, hi_w, 0, digits_text(hi_w, 4'hf), 1'b1, 1'b0);
		add_row("high hint", ACT_SUBMIT, 0, 16'h0, 0, "2 HI", 1'b1, 1'b0);
		add_row("high hint ends", ACT_WAIT, 0, 16'h0, HINT_CYCLES,
			digits_text(hi_w, 4'hf), 1'b1, 1'b0);
		add_row("low guess entry", ACT_WORD, 0, lo_w, 0, digits_text(lo_w, 4'hf), 1'b1, 1'b0);
		add_row("low hint", ACT_SUBMIT, 0, 16'h0, 0, "2 LO", 1'b1, 1'b0);
		add_row("submit in hint", ACT_SUBMIT, 0, 16'h0, 0, "    ", 1'b0, 1'b0);
		add_row("low hint ends", ACT_WAIT, 0, 16'h0, HINT_CYCLES,
			digits_text(lo_w, 4'hf), 1'b1, 1'b0);
		add_row("right guess entry", ACT_WORD, 0, secret_w, 0,
			digits_text(secret_w, 4'hf), 1'b1, 1'b0);
		add_row("win count", ACT_SUBMIT, 0, 16'h0, 0, "0003", 1'b1, 1'b1);	// hi, lo, match
		watch_cycles = 100;
		for (int r = 0; r < n_rows; r++)
			watch_cycles += row_wait[r] + 20 + 8*SCAN_DIV + 4*FLASH_CYCLES;
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		switch     = 4'h0;
		btn        = 4'h0;
		turn_sw    = 1'b0;
		guess_sw   = 1'b0;
		n_pass     = 0;
		n_fail     = 0;
		table_done = 1'b0;
		rng        = 32'h19e5e0e7;
		build_table();
		table_done = 1'b1;
		repeat (8) @(posedge clk);	// reset held 8 cycles
		#1;
		row_errs = 0;
		assert (anodes == 4'hf && cathodes == 8'hff && led == 8'h00) else
		begin
			$display("FAILED at %0t ns: outputs not dark in reset", $time);
			row_errs++;
		end
		rst_n = 1'b1;
		next_cycle();
		assert (anodes == 4'hf && cathodes == 8'hff) else
		begin
			$display("FAILED at %0t ns: display lit before the first scan step", $time);
			row_errs++;
		end
		report_test(0, "reset outputs");
		for (int r = 0; r < n_rows; r++)
		begin
			row_errs = 0;
			case (row_act[r])
			ACT_PRESS:  press_place(row_place[r], row_value[r][3:0]);
			ACT_WORD:   enter_word(row_value[r]);
			ACT_TURN:   raise_turn();
			ACT_SUBMIT: submit_guess();
			default:    ;
			endcase
			repeat (row_wait[r]) next_cycle();
			if (row_disp[r])
				check_display(row_text[r]);
			if (row_flash[r])
				check_flash();
			else
				assert (led == 8'h00) else
				begin
					$display("FAILED at %0t ns: leds %h lit before the win", $time, led);
					row_errs++;
				end
			report_test(r + 1, row_name[r]);
		end
		$display("tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		wait (table_done);
		#(watch_cycles * 10);	// table length in ns
		$display("timeout: the test table did not finish within %0d cycles", watch_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/guess_pkg.sv
verilog/digit_entry.sv
verilog/game_fsm.sv
verilog/display_scan.sv
verilog/guess_game_top.sv
bench/tb_guess_game.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench and design with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_guess_game -f verilog.f \
	&& ./obj_dir/Vtb_guess_game > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "no pass line in the log"; exit 1; }
echo "simulation passed"
